// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbTop
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG ?= all tests passed
VFLAGS ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rvCorePkg::aluOpT            op,
    input  logic [rvCorePkg::XLEN-1:0]  srcA,
    input  logic [rvCorePkg::XLEN-1:0]  srcB,
    output logic [rvCorePkg::XLEN-1:0]  result,
    output logic                        zero
);

    logic [4:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    assign shamt = srcB[4:0];
    assign lessSigned = $signed(srcA) < $signed(srcB);
    assign lessUnsigned = srcA < srcB;

    always_comb begin
        case (op)
            rvCorePkg::ALU_ADD:  result = srcA + srcB;
            rvCorePkg::ALU_SUB:  result = srcA - srcB;
            rvCorePkg::ALU_AND:  result = srcA & srcB;
            rvCorePkg::ALU_OR:   result = srcA | srcB;
            rvCorePkg::ALU_XOR:  result = srcA ^ srcB;
            rvCorePkg::ALU_SLT:  result = {{(rvCorePkg::XLEN-1){1'b0}}, lessSigned};
            rvCorePkg::ALU_SLTU: result = {{(rvCorePkg::XLEN-1){1'b0}}, lessUnsigned};
            rvCorePkg::ALU_SLL:  result = srcA << shamt;
            rvCorePkg::ALU_SRL:  result = srcA >> shamt;
            rvCorePkg::ALU_SRA:  result = $unsigned($signed(srcA) >>> shamt);
            default:             result = '0;
        endcase
    end

    // Branch compare uses sub, so zero means equal
    assign zero = (result == '0);

endmodule

// ==== design/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
    input  logic                        clk,
    input  logic                        write,
    input  logic [rvCorePkg::XLEN-1:0]  addr,
    input  logic [rvCorePkg::XLEN-1:0]  writeData,
    output logic [rvCorePkg::XLEN-1:0]  readData
);

    logic [rvCorePkg::XLEN-1:0] mem [rvCorePkg::DMEM_WORDS];
    logic [rvCorePkg::DMEM_ADDR_W-1:0] wordIdx;

    // Upper address bits ignored, so the space wraps
    assign wordIdx = addr[rvCorePkg::DMEM_ADDR_W+1:2];

    initial begin
        for (int i = 0; i < rvCorePkg::DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wordIdx] <= writeData;
        end
    end

    assign readData = mem[wordIdx];

    // Word stores only
    alignedStore: assert property (
        @(posedge clk) write |-> (addr[1:0] == 2'b00)
    ) else $error("misaligned store to %h", addr);

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  rvCorePkg::instrT            instr,
    output rvCorePkg::ctrlT             ctrl,
    output logic [rvCorePkg::XLEN-1:0]  imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic regFunctOk;
    logic immFunctOk;
    logic knownOpcode;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    // Only sub and sra may carry the alternate funct7
    assign regFunctOk = (funct7 == 7'h00) ||
        (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign immFunctOk = (funct3 == 3'b001) ? (funct7 == 7'h00) :
        (funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;

    assign knownOpcode = opcode inside {rvCorePkg::OP_REG, rvCorePkg::OP_IMM,
        rvCorePkg::OP_LOAD, rvCorePkg::OP_STORE, rvCorePkg::OP_BRANCH,
        rvCorePkg::OP_JAL, rvCorePkg::OP_JALR, rvCorePkg::OP_LUI};

    // Shared funct3 map for register and immediate forms
    function automatic rvCorePkg::aluOpT aluOpFor(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? rvCorePkg::ALU_SUB : rvCorePkg::ALU_ADD;
            3'b001: return rvCorePkg::ALU_SLL;
            3'b010: return rvCorePkg::ALU_SLT;
            3'b011: return rvCorePkg::ALU_SLTU;
            3'b100: return rvCorePkg::ALU_XOR;
            3'b101: return alt ? rvCorePkg::ALU_SRA : rvCorePkg::ALU_SRL;
            3'b110: return rvCorePkg::ALU_OR;
            default: return rvCorePkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        // Default is a nop that writes nothing and falls through
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.srcAZero = 1'b0;
        ctrl.aluOp = rvCorePkg::ALU_ADD;
        ctrl.resultSel = rvCorePkg::RES_ALU;
        ctrl.pcSel = rvCorePkg::PC_SEQ;
        ctrl.isBranch = 1'b0;
        ctrl.branchOnNotEqual = 1'b0;

        case (opcode)
            rvCorePkg::OP_REG: begin
                ctrl.regWrite = regFunctOk;
                ctrl.aluOp = aluOpFor(funct3, funct7[5]);
            end
            rvCorePkg::OP_IMM: begin
                ctrl.regWrite = immFunctOk;
                ctrl.aluSrcImm = 1'b1;
                // No subi, so bit 30 only matters for the right shift
                ctrl.aluOp = aluOpFor(funct3, funct7[5] && funct3 == 3'b101);
            end
            rvCorePkg::OP_LOAD: begin
                ctrl.regWrite = (funct3 == 3'b010);
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSel = rvCorePkg::RES_MEM;
            end
            rvCorePkg::OP_STORE: begin
                ctrl.memWrite = (funct3 == 3'b010);
                ctrl.aluSrcImm = 1'b1;
            end
            rvCorePkg::OP_BRANCH: begin
                // beq and bne only, compare via subtraction
                ctrl.isBranch = (funct3[2:1] == 2'b00);
                ctrl.branchOnNotEqual = funct3[0];
                ctrl.aluOp = rvCorePkg::ALU_SUB;
                ctrl.pcSel = rvCorePkg::PC_BRANCH;
            end
            rvCorePkg::OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.resultSel = rvCorePkg::RES_PC4;
                ctrl.pcSel = rvCorePkg::PC_JAL;
            end
            rvCorePkg::OP_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.resultSel = rvCorePkg::RES_PC4;
                    ctrl.pcSel = rvCorePkg::PC_JALR;
                end
            end
            rvCorePkg::OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.srcAZero = 1'b1;
            end
            default: ;
        endcase
    end

    // Immediate assembly per format
    always_comb begin
        case (opcode)
            rvCorePkg::OP_IMM, rvCorePkg::OP_LOAD, rvCorePkg::OP_JALR:
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            rvCorePkg::OP_STORE:
                imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            rvCorePkg::OP_BRANCH:
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.immHi, instr.b.immLo, 1'b0};
            rvCorePkg::OP_JAL:
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.immMid,
                       instr.j.imm11, instr.j.immLo, 1'b0};
            rvCorePkg::OP_LUI:
                imm = {instr.u.imm, 12'b0};
            default:
                imm = '0;
        endcase
    end

    // Every instruction fetched while running must be one we know
    knownOpcodeOutOfReset: assert property (
        @(posedge clk) disable iff (rst) knownOpcode
    ) else $error("unknown opcode %h executed", opcode);

endmodule

// ==== design/instrMemory.sv ====
`timescale 1ns/1ps

module instrMemory (
    input  logic                                clk,
    input  logic                                rst,
    input  rvCorePkg::progWriteT                progWrite,
    input  logic [rvCorePkg::IMEM_ADDR_W-1:0]   fetchAddr,
    output rvCorePkg::instrT                    instr
);

    logic [rvCorePkg::XLEN-1:0] mem [rvCorePkg::IMEM_WORDS];

    // Program load from the host, only while the core sits in reset
    always_ff @(posedge clk) begin
        if (rst && progWrite.en) begin
            mem[progWrite.addr] <= progWrite.data;
        end
    end

    // Fetch is purely combinational
    assign instr = mem[fetchAddr];

    // A load strobe while running would change code under the core
    progWriteOnlyInReset: assert property (
        @(posedge clk) progWrite.en |-> rst
    ) else $error("program write while core is running");

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                        clk,
    input  logic [4:0]                  rs1Addr,
    input  logic [4:0]                  rs2Addr,
    input  logic [4:0]                  rdAddr,
    input  logic                        rdWrite,
    input  logic [rvCorePkg::XLEN-1:0]  rdData,
    output logic [rvCorePkg::XLEN-1:0]  rs1Data,
    output logic [rvCorePkg::XLEN-1:0]  rs2Data,
    output logic [rvCorePkg::XLEN-1:0]  a0,
    output logic [rvCorePkg::XLEN-1:0]  a1,
    output logic [rvCorePkg::XLEN-1:0]  a7
);

    logic [rvCorePkg::XLEN-1:0] regs [rvCorePkg::REG_COUNT];

    // Registers power up cleared
    initial begin
        for (int i = 0; i < rvCorePkg::REG_COUNT; i++) begin
            regs[i] = '0;
        end
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (rdWrite && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    // Debug taps on x10, x11, x17
    assign a0 = regs[10];
    assign a1 = regs[11];
    assign a7 = regs[17];

endmodule

// ==== design/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
    input  logic                        clk,
    input  logic                        rst,
    input  rvCorePkg::progWriteT        progWrite,
    output rvCorePkg::commitT           commit,
    output logic [rvCorePkg::XLEN-1:0]  a0,
    output logic [rvCorePkg::XLEN-1:0]  a1,
    output logic [rvCorePkg::XLEN-1:0]  a7
);

    // Fetch and decode
    logic [rvCorePkg::XLEN-1:0] pc;
    logic [rvCorePkg::XLEN-1:0] nextPc;
    rvCorePkg::instrT instr;
    rvCorePkg::ctrlT ctrl;
    logic [rvCorePkg::XLEN-1:0] imm;

    // Register file and execute
    logic [4:0] rs1Addr;
    logic [rvCorePkg::XLEN-1:0] rs1Data;
    logic [rvCorePkg::XLEN-1:0] rs2Data;
    logic [rvCorePkg::XLEN-1:0] srcB;
    logic [rvCorePkg::XLEN-1:0] aluResult;
    logic zero;
    logic [rvCorePkg::XLEN-1:0] readData;

    // Write back and next pc
    logic rdWrite;
    logic memWrite;
    logic [rvCorePkg::XLEN-1:0] result;
    logic [rvCorePkg::XLEN-1:0] pcPlus4;
    logic [rvCorePkg::XLEN-1:0] pcTarget;
    logic branchTaken;

    instrMemory instrMem (
        .clk(clk),
        .rst(rst),
        .progWrite(progWrite),
        .fetchAddr(pc[rvCorePkg::IMEM_ADDR_W+1:2]),
        .instr(instr)
    );

    decoder dec (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .ctrl(ctrl),
        .imm(imm)
    );

    // lui reads x0 so the ALU passes the immediate through
    assign rs1Addr = ctrl.srcAZero ? 5'd0 : instr.r.rs1;

    // No architectural writes while held in reset
    assign rdWrite = ctrl.regWrite && !rst;
    assign memWrite = ctrl.memWrite && !rst;

    regFile regs (
        .clk(clk),
        .rs1Addr(rs1Addr),
        .rs2Addr(instr.r.rs2),
        .rdAddr(instr.r.rd),
        .rdWrite(rdWrite),
        .rdData(result),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .a0(a0),
        .a1(a1),
        .a7(a7)
    );

    assign srcB = ctrl.aluSrcImm ? imm : rs2Data;

    alu aluUnit (
        .op(ctrl.aluOp),
        .srcA(rs1Data),
        .srcB(srcB),
        .result(aluResult),
        .zero(zero)
    );

    dataMemory dataMem (
        .clk(clk),
        .write(memWrite),
        .addr(aluResult),
        .writeData(rs2Data),
        .readData(readData)
    );

    assign pcPlus4 = pc + 32'd4;
    assign pcTarget = pc + imm;
    assign branchTaken = ctrl.isBranch && (zero != ctrl.branchOnNotEqual);

    always_comb begin
        case (ctrl.resultSel)
            rvCorePkg::RES_MEM: result = readData;
            rvCorePkg::RES_PC4: result = pcPlus4;
            default:            result = aluResult;
        endcase
    end

    always_comb begin
        case (ctrl.pcSel)
            rvCorePkg::PC_BRANCH: nextPc = branchTaken ? pcTarget : pcPlus4;
            rvCorePkg::PC_JAL:    nextPc = pcTarget;
            // jalr target with bit 0 cleared
            rvCorePkg::PC_JALR:   nextPc = {aluResult[rvCorePkg::XLEN-1:1], 1'b0};
            default:              nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Trace of the instruction retiring at the coming edge
    assign commit.valid = !rst;
    assign commit.pc = pc;
    assign commit.rdAddr = instr.r.rd;
    assign commit.rdWrite = rdWrite;
    assign commit.rdData = result;
    assign commit.nextPc = nextPc;

endmodule

// ==== design/rvCorePkg.sv ====
package rvCorePkg;

    // Sizes
    localparam int XLEN = 32;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 64;
    localparam int REG_COUNT = 32;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } aluOpT;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pcSelT;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} resultSelT;

    // Instruction format views, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic imm12;
        logic [5:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;
        logic imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } uTypeT;

    typedef struct packed {
        logic imm20;
        logic [9:0] immLo;
        logic imm11;
        logic [7:0] immMid;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrT;

    typedef struct packed {
        logic regWrite;
        logic memWrite;
        logic aluSrcImm;
        logic srcAZero;
        aluOpT aluOp;
        resultSelT resultSel;
        pcSelT pcSel;
        logic isBranch;
        logic branchOnNotEqual;
    } ctrlT;

    // One record per retired instruction
    typedef struct packed {
        logic valid;
        logic [XLEN-1:0] pc;
        logic [4:0] rdAddr;
        logic rdWrite;
        logic [XLEN-1:0] rdData;
        logic [XLEN-1:0] nextPc;
    } commitT;

    typedef struct packed {
        logic en;
        logic [IMEM_ADDR_W-1:0] addr;
        logic [XLEN-1:0] data;
    } progWriteT;

endpackage

// ==== tb.f ====
design/rvCorePkg.sv
design/instrMemory.sv
design/decoder.sv
design/regFile.sv
design/alu.sv
design/dataMemory.sv
design/rvCore.sv
testbench/tbChecker.sv
testbench/tbTop.sv

// ==== testbench/tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker (
    input  logic                        clk,
    input  logic                        rst,
    input  rvCorePkg::progWriteT        progWrite,
    input  rvCorePkg::commitT           commit,
    input  logic [rvCorePkg::XLEN-1:0]  a0,
    input  logic [rvCorePkg::XLEN-1:0]  a1,
    input  logic [rvCorePkg::XLEN-1:0]  a7,
    output int                          errorCount,
    output logic                        halted
);

    logic [31:0] progCopy [rvCorePkg::IMEM_WORDS];
    logic [31:0] modelRegs [rvCorePkg::REG_COUNT];
    logic [31:0] modelMem [rvCorePkg::DMEM_WORDS];
    logic [31:0] modelPc;
    int errors = 0;
    logic haltSeen = 1'b0;

    assign errorCount = errors;
    assign halted = haltSeen;

    task automatic expectEqual(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // ISA semantics of the register and immediate ops
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic resetModel();
        for (int i = 0; i < rvCorePkg::REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < rvCorePkg::DMEM_WORDS; i++) begin
            modelMem[i] = '0;
        end
        modelPc = '0;
        haltSeen = 1'b0;
    endtask

    task automatic stepModel();
        logic [31:0] ins;
        logic [4:0] rd;
        logic [2:0] f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] addr;
        logic expWrite;
        logic [31:0] expData;
        logic [31:0] expNext;
        ins = progCopy[modelPc[9:2]];
        rd = ins[11:7];
        f3 = ins[14:12];
        a = modelRegs[ins[19:15]];
        b = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        expWrite = 1'b0;
        expData = '0;
        expNext = modelPc + 32'd4;
        case (ins[6:0])
            rvCorePkg::OP_REG: begin
                expWrite = 1'b1;
                expData = aluModel(f3, ins[30], a, b);
            end
            rvCorePkg::OP_IMM: begin
                expWrite = 1'b1;
                expData = aluModel(f3, ins[30] && f3 == 3'b101, a, immI);
            end
            rvCorePkg::OP_LUI: begin
                expWrite = 1'b1;
                expData = {ins[31:12], 12'b0};
            end
            rvCorePkg::OP_LOAD: begin
                expWrite = 1'b1;
                expData = modelMem[(a + immI) >> 2 & 32'h3f];
            end
            rvCorePkg::OP_STORE: ;
            rvCorePkg::OP_BRANCH: begin
                if ((a == b) != f3[0]) begin
                    expNext = modelPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                        ins[11:8], 1'b0};
                end
            end
            rvCorePkg::OP_JAL: begin
                expWrite = 1'b1;
                expData = modelPc + 32'd4;
                expNext = modelPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                    ins[30:21], 1'b0};
            end
            rvCorePkg::OP_JALR: begin
                expWrite = 1'b1;
                expData = modelPc + 32'd4;
                expNext = (a + immI) & ~32'd1;
            end
            default: begin
                errors++;
                $display("Model met an unsupported instruction %h at pc %h", ins, modelPc);
            end
        endcase

        expectEqual("commit.pc", commit.pc, modelPc);
        expectEqual("commit.rdWrite", 32'(commit.rdWrite), 32'(expWrite));
        if (expWrite) begin
            expectEqual("commit.rdAddr", 32'(commit.rdAddr), 32'(rd));
            expectEqual("commit.rdData", commit.rdData, expData);
        end
        expectEqual("commit.nextPc", commit.nextPc, expNext);

        // Architectural update, x0 stays zero
        if (ins[6:0] == rvCorePkg::OP_STORE) begin
            modelMem[addr[7:2]] = b;
        end
        if (expWrite && rd != 5'd0) begin
            modelRegs[rd] = expData;
        end
        if (commit.nextPc == commit.pc) begin
            haltSeen = 1'b1;
        end
        modelPc = expNext;
    endtask

    // Sampled mid-cycle, where the combinational trace has settled
    always @(negedge clk) begin
        if (rst) begin
            if (progWrite.en) begin
                progCopy[progWrite.addr] = progWrite.data;
            end
            resetModel();
            expectEqual("commit.valid", 32'(commit.valid), 32'd0);
            expectEqual("commit.pc", commit.pc, 32'd0);
        end else begin
            // Taps show the state left by earlier commits
            expectEqual("a0", a0, modelRegs[10]);
            expectEqual("a1", a1, modelRegs[11]);
            expectEqual("a7", a7, modelRegs[17]);
            expectEqual("commit.valid", 32'(commit.valid), 32'd1);
            if (commit.valid === 1'b1) begin
                stepModel();
            end
        end
    end

endmodule

// ==== testbench/tbTop.sv ====
`timescale 1ns/1ps

module tbTop;

    localparam int BODY_LEN = 120;
    localparam int HALT_TIMEOUT = 2000;

    logic clk;
    logic rst;
    rvCorePkg::progWriteT progWrite;
    rvCorePkg::commitT commit;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a7;
    int errorCount;
    logic halted;

    logic [31:0] lfsrState = 32'd11;
    logic [31:0] progWords [rvCorePkg::IMEM_WORDS];
    int progLen;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    rvCore DUT (
        .clk(clk),
        .rst(rst),
        .progWrite(progWrite),
        .commit(commit),
        .a0(a0),
        .a1(a1),
        .a7(a7)
    );

    tbChecker scoreboard (
        .clk(clk),
        .rst(rst),
        .progWrite(progWrite),
        .commit(commit),
        .a0(a0),
        .a1(a1),
        .a7(a7),
        .errorCount(errorCount),
        .halted(halted)
    );

    // Galois LFSR, taps 32 22 2 1
    function automatic logic nextRandomBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], nextRandomBit()};
        end
        return value;
    endfunction

    // x0 to x15, and x17 in place of x15 half the time so the a7 tap sees writes
    function automatic logic [4:0] randomReg();
        logic [31:0] r;
        r = randomBits(4);
        if (r[3:0] == 4'd15) begin
            if (nextRandomBit()) begin
                r = 32'd17;
            end
        end
        return r[4:0];
    endfunction

    // Forward jump of 1 to 8 words, never past the halt word
    function automatic int forwardSteps(input int from);
        logic [31:0] r;
        int steps;
        r = randomBits(3);
        steps = int'(r) + 1;
        if (from + steps > BODY_LEN) begin
            steps = BODY_LEN - from;
        end
        return steps;
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] encodeB(input logic [12:0] off, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvCorePkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvCorePkg::OP_JAL};
    endfunction

    task automatic buildProgram();
        int idx;
        int steps;
        logic [31:0] kind;
        logic [31:0] bits;
        logic [2:0] f3;
        logic alt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        bit jumpTarget [BODY_LEN + 1];
        for (int i = 0; i <= BODY_LEN; i++) begin
            jumpTarget[i] = 1'b0;
        end
        idx = 0;
        while (idx < BODY_LEN) begin
            kind = randomBits(4);
            rd = randomReg();
            rs1 = randomReg();
            rs2 = randomReg();
            bits = randomBits(20);
            f3 = bits[2:0];
            alt = nextRandomBit();
            case (kind[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    // Alternate funct7 only for sub and sra
                    if (f3 != 3'b000 && f3 != 3'b101) begin
                        alt = 1'b0;
                    end
                    progWords[idx] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rvCorePkg::OP_REG};
                end
                4'd4, 4'd5, 4'd6: begin
                    imm = bits[19:8];
                    if (f3 == 3'b001) begin
                        imm[11:5] = 7'h00;
                    end else if (f3 == 3'b101) begin
                        imm[11:5] = {1'b0, alt, 5'b0};
                    end
                    progWords[idx] = encodeI(imm, rs1, f3, rd, rvCorePkg::OP_IMM);
                end
                4'd7: progWords[idx] = {bits[19:0], rd, rvCorePkg::OP_LUI};
                4'd8, 4'd9: begin
                    progWords[idx] = encodeI({4'b0, bits[5:0], 2'b00}, 5'd0, 3'b010, rd,
                        rvCorePkg::OP_LOAD);
                end
                4'd10, 4'd11: begin
                    imm = {4'b0, bits[5:0], 2'b00};
                    progWords[idx] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0],
                        rvCorePkg::OP_STORE};
                end
                4'd12, 4'd13: begin
                    // Equal operands now and then so beq gets taken
                    if (alt) begin
                        rs2 = rs1;
                    end
                    steps = forwardSteps(idx);
                    jumpTarget[idx + steps] = 1'b1;
                    progWords[idx] = encodeB(13'(steps * 4), rs2, rs1, {2'b00, f3[0]});
                end
                4'd14: begin
                    steps = forwardSteps(idx);
                    jumpTarget[idx + steps] = 1'b1;
                    progWords[idx] = encodeJ(21'(steps * 4), rd);
                end
                default: begin
                    // The addi and jalr words must not be entered by an earlier jump
                    if (idx + 3 <= BODY_LEN && !jumpTarget[idx + 1] && !jumpTarget[idx + 2]) begin
                        // lui and addi build the target, then jalr
                        if (rs1 == 5'd0) begin
                            rs1 = 5'd1;
                        end
                        steps = forwardSteps(idx + 2);
                        jumpTarget[idx + 2 + steps] = 1'b1;
                        progWords[idx] = {20'd0, rs1, rvCorePkg::OP_LUI};
                        progWords[idx + 1] = encodeI(12'((idx + 2 + steps) * 4), rs1, 3'b000,
                            rs1, rvCorePkg::OP_IMM);
                        progWords[idx + 2] = encodeI(12'd0, rs1, 3'b000, rd,
                            rvCorePkg::OP_JALR);
                        idx = idx + 2;
                    end else begin
                        progWords[idx] = encodeI({7'b0, rs2}, rs1, 3'b000, rd,
                            rvCorePkg::OP_IMM);
                    end
                end
            endcase
            idx++;
        end
        // Self-loop halt
        progWords[BODY_LEN] = encodeJ(21'd0, 5'd0);
        progLen = BODY_LEN + 1;
    endtask

    initial begin
        int cycles;
        rst = 1'b1;
        progWrite = '0;
        buildProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWrite.en <= 1'b1;
            progWrite.addr <= 8'(i);
            progWrite.data <= progWords[i];
        end
        @(posedge clk);
        progWrite <= '0;
        // Reset stays up 8 cycles past the load
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("no halt before timeout");
        end
        repeat (2) @(posedge clk);
        $display("Run finished after %0d cycles with %0d errors", cycles, errorCount);
        if (errorCount == 0 && halted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
